//--- rvCore.f
verilog/rvIsaPkg.sv
verilog/rvPipePkg.sv
verilog/coreFetch.sv
verilog/coreDecode.sv
verilog/coreExecute.sv
verilog/coreResult.sv
verilog/rvCore.sv
tb/rvCore_assert.sv
tb/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rvCoreTb -f rvCore.f -o rvCoreSim

status=0
./obj_dir/rvCoreSim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test FAILED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"

//--- tb/rvCoreTb.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the pipelined core
// Programs go into a 64-word ROM, unused words hold jal x0, 0
// Data memory is 256 words and is refilled while reset is held
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvCoreTb;
	import rvIsaPkg::*;

	localparam int   ResetCycles  = 16;
	localparam int   SettleCycles = 8;
	// Sum of the program lengths of all tests
	localparam int   TotalInstr   = 61;
	// jal x0, 0
	localparam wordT SelfLoop     = 32'h0000_006F;

	logic clk;
	logic rstN;
	wordT instrData;
	wordT memData;
	addrT pc;
	addrT rwAddress;
	wordT writeData;
	logic memRead;
	logic memWrite;

	wordT rom [64];
	wordT dmem [256];
	int   progLen;
	addrT storeAddr [$];
	wordT storeData [$];
	addrT expAddr [$];
	wordT expData [$];
	int   seed;
	int   errors;
	int   checks;

	rvCore rvCore_inst (
		.clk(clk), .rstN(rstN), .InstrData(instrData), .MemData(memData), .PC(pc),
		.RWAddress(rwAddress), .WriteData(writeData), .MemRead(memRead), .MemWrite(memWrite)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoders and reference values
	////////////////////////////////////////////////////////////////////////////

	function automatic wordT encReg(input logic [2:0] f3, input logic sub, input int rd,
			input int rs1, input int rs2);
		return {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OpReg};
	endfunction

	function automatic wordT encImm(input logic [2:0] f3, input int rd, input int rs1,
			input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], OpImm};
	endfunction

	function automatic wordT encLoad(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OpLoad};
	endfunction

	function automatic wordT encStore(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OpStore};
	endfunction

	function automatic wordT encBranch(input logic [2:0] f3, input int rs1, input int rs2,
			input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OpBranch};
	endfunction

	function automatic wordT encJal(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OpJal};
	endfunction

	function automatic wordT sext12(input wordT r);
		return {{20{r[11]}}, r[11:0]};
	endfunction

	// Register result as the ISA defines it
	function automatic wordT isaAlu(input logic [2:0] f3, input logic sub, input wordT x,
			input wordT y);
		case (f3)
			Funct3Add: return sub ? x - y : x + y;
			Funct3Slt: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			Funct3Xor: return x ^ y;
			Funct3Or:  return x | y;
			default:   return x & y;
		endcase
	endfunction

	function automatic wordT fillWord(input int i);
		return 32'hD47A_0000 | (i << 2);
	endfunction

	function automatic wordT fetchWord(input addrT a);
		return (a[31:8] == '0) ? rom[a[7:2]] : SelfLoop;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Memory models and store monitor
	////////////////////////////////////////////////////////////////////////////

	initial begin
		instrData = '0;
		memData   = '0;
		forever begin
			@(posedge clk);
			if (!rstN) begin
				for (int i = 0; i < 256; i++) begin
					dmem[i[7:0]] = fillWord(i);
				end
				storeAddr.delete();
				storeData.delete();
			end else if (memWrite) begin
				dmem[rwAddress[9:2]] = writeData;
				storeAddr.push_back(rwAddress);
				storeData.push_back(writeData);
			end
			#1;
			instrData = fetchWord(pc);
			// Read data only while a load is on the port
			memData   = memRead ? dmem[rwAddress[9:2]] : '0;
		end
	end

	task automatic emit(input wordT w);
		rom[progLen[5:0]] = w;
		progLen++;
	endtask

	task automatic expectStore(input int addr, input wordT data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic checkAddr(input string test, input addrT exp, input addrT act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: address expected %h, actual %h", test, exp, act);
		end
	endtask

	task automatic checkWord(input string test, input wordT exp, input wordT act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: data expected %h, actual %h", test, exp, act);
		end
	endtask

	// Holds reset while the next program is loaded
	task automatic beginTest();
		@(posedge clk);
		#1;
		rstN = 1'b0;
		rom = '{default: SelfLoop};
		progLen = 0;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic runTest(input string test);
		repeat (ResetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;
		while (storeAddr.size() < expAddr.size()) begin
			@(negedge clk);
		end
		// Late stores from a wrong path would still show up here
		repeat (SettleCycles) @(negedge clk);
		if (storeAddr.size() != expAddr.size()) begin
			errors++;
			$display("%s: saw %0d stores but expected %0d", test, storeAddr.size(),
				expAddr.size());
		end
		for (int i = 0; i < expAddr.size(); i++) begin
			checkAddr($sformatf("%s store %0d", test, i), expAddr[i], storeAddr[i]);
			checkWord($sformatf("%s store %0d", test, i), expData[i], storeData[i]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic regOpStore(input logic [2:0] f3, input logic sub, input wordT a,
			input wordT b, input int addr);
		emit(encReg(f3, sub, 3, 1, 2));
		emit(encStore(3, 0, addr));
		expectStore(addr, isaAlu(f3, sub, a, b));
	endtask

	task automatic immOpStore(input logic [2:0] f3, input wordT a, input wordT c,
			input int addr);
		emit(encImm(f3, 4, 1, c));
		emit(encStore(4, 0, addr));
		expectStore(addr, isaAlu(f3, 1'b0, a, c));
	endtask

	task automatic testAlu();
		wordT a;
		wordT b;
		wordT c;
		a = sext12($random(seed));
		b = sext12($random(seed));
		c = sext12($random(seed));
		beginTest();
		emit(encImm(Funct3Add, 1, 0, a));
		emit(encImm(Funct3Add, 2, 0, b));
		regOpStore(Funct3Add, 1'b0, a, b, 0);
		regOpStore(Funct3Add, 1'b1, a, b, 4);
		regOpStore(Funct3And, 1'b0, a, b, 8);
		regOpStore(Funct3Or, 1'b0, a, b, 12);
		regOpStore(Funct3Xor, 1'b0, a, b, 16);
		regOpStore(Funct3Slt, 1'b0, a, b, 20);
		immOpStore(Funct3Add, a, c, 64);
		immOpStore(Funct3And, a, c, 68);
		immOpStore(Funct3Or, a, c, 72);
		immOpStore(Funct3Xor, a, c, 76);
		immOpStore(Funct3Slt, a, c, 80);
		runTest("alu");
	endtask

	// Producers at distance 1, 2 and 3 from their consumers
	task automatic testChains();
		wordT r1;
		wordT r3;
		wordT r6;
		wordT r2;
		wordT r4;
		r1 = sext12($random(seed));
		r3 = sext12($random(seed));
		r6 = sext12($random(seed));
		r2 = isaAlu(Funct3Add, 1'b0, r1, r1);
		r4 = isaAlu(Funct3Add, 1'b1, r2, r3);
		beginTest();
		emit(encImm(Funct3Add, 1, 0, r1));
		emit(encReg(Funct3Add, 1'b0, 2, 1, 1));
		emit(encImm(Funct3Add, 3, 0, r3));
		emit(encReg(Funct3Add, 1'b1, 4, 2, 3));
		emit(encImm(Funct3Add, 5, 0, 12'h123));
		emit(encImm(Funct3Add, 6, 0, r6));
		emit(encReg(Funct3Xor, 1'b0, 7, 4, 6));
		emit(encStore(2, 0, 64));
		emit(encStore(4, 0, 68));
		emit(encStore(7, 0, 72));
		expectStore(64, r2);
		expectStore(68, r4);
		expectStore(72, isaAlu(Funct3Xor, 1'b0, r4, r6));
		runTest("chains");
	endtask

	task automatic testLoadUse();
		wordT v;
		v = sext12($random(seed));
		beginTest();
		emit(encImm(Funct3Add, 1, 0, v));
		emit(encStore(1, 0, 128));
		emit(encLoad(2, 0, 128));
		emit(encReg(Funct3Add, 1'b0, 3, 2, 1));
		emit(encStore(3, 0, 132));
		emit(encLoad(4, 0, 200));
		emit(encImm(Funct3Add, 5, 4, 1));
		emit(encStore(5, 0, 136));
		expectStore(128, v);
		expectStore(132, v + v);
		expectStore(136, fillWord(50) + 32'd1);
		runTest("loadUse");
	endtask

	// Stores at 256 and 260 sit on skipped paths
	task automatic testBranch();
		beginTest();
		emit(encImm(Funct3Add, 1, 0, 5));
		emit(encImm(Funct3Add, 2, 0, 5));
		emit(encBranch(Funct3Beq, 1, 2, 8));
		emit(encStore(1, 0, 256));
		emit(encImm(Funct3Add, 3, 0, 9));
		emit(encBranch(Funct3Bne, 3, 1, 8));
		emit(encStore(3, 0, 260));
		emit(encStore(1, 0, 264));
		emit(encBranch(Funct3Bne, 1, 2, 8));
		emit(encStore(2, 0, 268));
		emit(encImm(Funct3Add, 4, 0, 6));
		emit(encBranch(Funct3Beq, 4, 1, 8));
		emit(encStore(4, 0, 272));
		emit(encStore(1, 0, 276));
		expectStore(264, 32'd5);
		expectStore(268, 32'd5);
		expectStore(272, 32'd6);
		expectStore(276, 32'd5);
		runTest("branch");
	endtask

	task automatic testJal();
		addrT jalPc;
		jalPc = 32'd4;
		beginTest();
		emit(encImm(Funct3Add, 1, 0, 1));
		emit(encJal(5, 12));
		emit(encStore(1, 0, 300));
		emit(encStore(1, 0, 304));
		emit(encStore(5, 0, 308));
		expectStore(308, jalPc + 32'd4);
		runTest("jal");
	endtask

	initial begin
		rstN    = 1'b0;
		seed    = 75;
		errors  = 0;
		checks  = 0;
		progLen = 0;
		testAlu();
		testChains();
		testLoadUse();
		testBranch();
		testJal();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Generous bound of ten cycles per instruction
	initial begin
		repeat (TotalInstr * 10) @(posedge clk);
		$display("Timeout: tests did not finish within %0d cycles", TotalInstr * 10);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- tb/rvCore_assert.sv
////////////////////////////////////////////////////////////////////////////
// Data memory port rules of the core, bound into every rvCore instance
// Only word accesses exist, so every access address is word aligned
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvCore_assert (
	input logic           clk,
	input logic           rstN,
	input logic           MemRead,
	input logic           MemWrite,
	input rvIsaPkg::addrT RWAddress
);

	// One shared data port, one access per cycle
	readWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(MemRead && MemWrite))
		else $error("MemRead and MemWrite are high in the same cycle");

	// Memory stage register is cleared by the first reset edge
	quietInReset: assert property (@(posedge clk) !rstN |=> (!MemRead && !MemWrite))
		else $error("Data memory access issued while reset is held");

	alignedAccess: assert property (@(posedge clk) disable iff (!rstN)
		(MemRead || MemWrite) |-> (RWAddress[1:0] == 2'b00))
		else $error("Data memory access to unaligned address %h", RWAddress);

endmodule

bind rvCore rvCore_assert rvCore_assert_inst (
	.clk(clk), .rstN(rstN), .MemRead(MemRead), .MemWrite(MemWrite), .RWAddress(RWAddress)
);

//--- verilog/rvCore.sv
////////////////////////////////////////////////////////////////////////////
// Five-stage RV32I core, rising-edge clocked
// Instruction and data memories are external and combinational
// No back-pressure, every access completes in the cycle it is issued
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvCore (
	input  logic           clk,
	input  logic           rstN,
	input  rvIsaPkg::wordT InstrData,
	input  rvIsaPkg::wordT MemData,
	output rvIsaPkg::addrT PC,
	output rvIsaPkg::addrT RWAddress,
	output rvIsaPkg::wordT WriteData,
	output logic           MemRead,
	output logic           MemWrite
);

	logic              stall;
	logic              redirect;
	rvIsaPkg::addrT    target;
	rvIsaPkg::addrT    fdPc;
	rvIsaPkg::wordT    fdInstr;
	rvPipePkg::decExT  decEx;
	rvPipePkg::ctrlT   exCtrl;
	rvIsaPkg::regIdxT  exRd;
	rvPipePkg::exMemT  exMem;
	rvPipePkg::wbT     wb;

	coreFetch coreFetch_inst (
		.clk(clk), .rstN(rstN), .InstrData(InstrData), .stall(stall),
		.redirect(redirect), .target(target), .pc(PC), .fdPc(fdPc), .fdInstr(fdInstr)
	);

	coreDecode coreDecode_inst (
		.clk(clk), .rstN(rstN), .fdPc(fdPc), .fdInstr(fdInstr), .exCtrl(exCtrl),
		.exRd(exRd), .memStage(exMem), .wb(wb), .stall(stall), .redirect(redirect),
		.target(target), .decEx(decEx)
	);

	coreExecute coreExecute_inst (
		.clk(clk), .rstN(rstN), .decEx(decEx), .memStage(exMem), .wb(wb),
		.exMem(exMem), .exCtrl(exCtrl), .exRd(exRd)
	);

	coreResult coreResult_inst (
		.clk(clk), .rstN(rstN), .exMem(exMem), .MemData(MemData), .wb(wb)
	);

	// Memory stage straight onto the data ports
	assign RWAddress = exMem.aluOut;
	assign WriteData = exMem.storeData;
	assign MemRead   = exMem.memRead;
	assign MemWrite  = exMem.memWrite;

endmodule

//--- verilog/coreResult.sv
////////////////////////////////////////////////////////////////////////////
// Memory/writeback register and writeback data select
// MemData is sampled in the cycle that the load drives the memory ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module coreResult (
	input  logic             clk,
	input  logic             rstN,
	input  rvPipePkg::exMemT exMem,
	input  rvIsaPkg::wordT   MemData,
	output rvPipePkg::wbT    wb
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	logic   wbRegWrite;
	logic   wbMemRead;
	regIdxT wbRd;
	wordT   wbAlu;
	wordT   wbLoad;

	// Writes to x0 are dropped here, once for both consumers
	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbRegWrite <= 1'b0;
		end else begin
			wbRegWrite <= exMem.regWrite && (exMem.rd != ZeroReg);
		end
	end

	always_ff @(posedge clk) begin
		wbMemRead <= exMem.memRead;
		wbRd      <= exMem.rd;
		wbAlu     <= exMem.aluOut;
		wbLoad    <= MemData;
	end

	assign wb.regWrite = wbRegWrite;
	assign wb.rd       = wbRd;
	assign wb.data     = wbMemRead ? wbLoad : wbAlu;

endmodule

//--- verilog/coreExecute.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage with forwarding, ALU and execute/memory register
// A load in the memory stage is never forwarded, decode stalls instead
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module coreExecute (
	input  logic              clk,
	input  logic              rstN,
	input  rvPipePkg::decExT  decEx,
	input  rvPipePkg::exMemT  memStage,
	input  rvPipePkg::wbT     wb,
	output rvPipePkg::exMemT  exMem,
	output rvPipePkg::ctrlT   exCtrl,
	output rvIsaPkg::regIdxT  exRd
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	// Memory stage first, then writeback, then the decoded value
	function automatic wordT fwd(input regIdxT src, input wordT regVal, input exMemT ms,
			input wbT w);
		wordT val;
		val = regVal;
		if (src != ZeroReg && ms.regWrite && !ms.memRead && ms.rd == src) begin
			val = ms.aluOut;
		end else if (src != ZeroReg && w.regWrite && w.rd == src) begin
			val = w.data;
		end
		return val;
	endfunction

	wordT  fwdA, fwdB, opA, opB, aluOut;
	exMemT exMemNext;

	assign fwdA = fwd(decEx.rs1, decEx.rs1Val, memStage, wb);
	assign fwdB = fwd(decEx.rs2, decEx.rs2Val, memStage, wb);
	assign opA  = decEx.ctrl.aluPc ? decEx.pc : fwdA;
	assign opB  = decEx.ctrl.aluImm ? decEx.imm : fwdB;

	always_comb begin
		case (decEx.ctrl.aluOp)
			AluSub:  aluOut = opA - opB;
			AluAnd:  aluOut = opA & opB;
			AluOr:   aluOut = opA | opB;
			AluXor:  aluOut = opA ^ opB;
			AluSlt:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
			default: aluOut = opA + opB;
		endcase
	end

	// Seen by decode for load-use and branch hazards
	assign exCtrl = decEx.ctrl;
	assign exRd   = decEx.rd;

	always_comb begin
		exMemNext.aluOut    = aluOut;
		exMemNext.storeData = fwdB;
		exMemNext.rd        = decEx.rd;
		exMemNext.regWrite  = decEx.ctrl.regWrite;
		exMemNext.memRead   = decEx.ctrl.memRead;
		exMemNext.memWrite  = decEx.ctrl.memWrite;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem.regWrite <= 1'b0;
			exMem.memRead  <= 1'b0;
			exMem.memWrite <= 1'b0;
		end else begin
			exMem <= exMemNext;
		end
	end

endmodule

//--- verilog/coreDecode.sv
////////////////////////////////////////////////////////////////////////////
// Decode stage with register file, hazard checks and early branch/jal
// Branches compare register-file values, so they wait for in-flight sources
// Register file reads are write-through from the writeback port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module coreDecode (
	input  logic              clk,
	input  logic              rstN,
	input  rvIsaPkg::addrT    fdPc,
	input  rvIsaPkg::wordT    fdInstr,
	input  rvPipePkg::ctrlT   exCtrl,
	input  rvIsaPkg::regIdxT  exRd,
	input  rvPipePkg::exMemT  memStage,
	input  rvPipePkg::wbT     wb,
	output logic              stall,
	output logic              redirect,
	output rvIsaPkg::addrT    target,
	output rvPipePkg::decExT  decEx
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	function automatic aluOpT aluSel(input logic [2:0] f3, input logic sub);
		aluOpT op;
		case (f3)
			Funct3Add: op = sub ? AluSub : AluAdd;
			Funct3Slt: op = AluSlt;
			Funct3Xor: op = AluXor;
			Funct3Or:  op = AluOr;
			Funct3And: op = AluAnd;
			default:   op = AluAdd;
		endcase
		return op;
	endfunction

	// True when a writer of rd feeds one of the used sources
	function automatic logic srcHit(input logic we, input regIdxT rd, input regIdxT s1,
			input regIdxT s2, input logic use1, input logic use2);
		return we && (rd != ZeroReg) && ((use1 && rd == s1) || (use2 && rd == s2));
	endfunction

	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	regIdxT     rs1, rs2, rd;
	wordT       immI, immS, immB, immJ, imm;
	wordT       rs1Val, rs2Val;
	wordT       regs [32];
	ctrlT       ctrl;
	logic       isBranch, isJal, useRs1, useRs2, taken, loadUse, branchWait;
	decExT      decExNext;

	assign opcode = fdInstr[6:0];
	assign funct3 = fdInstr[14:12];
	assign funct7 = fdInstr[31:25];
	assign rs1    = fdInstr[19:15];
	assign rs2    = fdInstr[24:20];
	assign rd     = fdInstr[11:7];

	assign immI = {{20{fdInstr[31]}}, fdInstr[31:20]};
	assign immS = {{20{fdInstr[31]}}, fdInstr[31:25], fdInstr[11:7]};
	assign immB = {{19{fdInstr[31]}}, fdInstr[31], fdInstr[7], fdInstr[30:25],
		fdInstr[11:8], 1'b0};
	assign immJ = {{11{fdInstr[31]}}, fdInstr[31], fdInstr[19:12], fdInstr[20],
		fdInstr[30:21], 1'b0};

	always_comb begin
		ctrl     = '0;
		isBranch = 1'b0;
		isJal    = 1'b0;
		useRs1   = 1'b0;
		useRs2   = 1'b0;
		imm      = immI;
		case (opcode)
			OpReg: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluSel(funct3, funct7[Funct7Sub]);
				useRs1        = 1'b1;
				useRs2        = 1'b1;
			end
			OpImm: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluImm   = 1'b1;
				ctrl.aluOp    = aluSel(funct3, 1'b0);
				useRs1        = 1'b1;
			end
			OpLoad: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.aluImm   = 1'b1;
				useRs1        = 1'b1;
			end
			OpStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluImm   = 1'b1;
				imm           = immS;
				useRs1        = 1'b1;
				useRs2        = 1'b1;
			end
			OpBranch: begin
				isBranch = 1'b1;
				useRs1   = 1'b1;
				useRs2   = 1'b1;
			end
			// Link value pc+4 is formed by the ALU in execute
			OpJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluPc    = 1'b1;
				ctrl.aluImm   = 1'b1;
				imm           = PcStep;
				isJal         = 1'b1;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wb.regWrite) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rs1Val = (rs1 == ZeroReg) ? '0 : (wb.regWrite && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2Val = (rs2 == ZeroReg) ? '0 : (wb.regWrite && wb.rd == rs2) ? wb.data : regs[rs2];

	////////////////////////////////////////////////////////////////////////////
	// Hazards and early resolution
	////////////////////////////////////////////////////////////////////////////

	assign loadUse    = srcHit(exCtrl.memRead, exRd, rs1, rs2, useRs1, useRs2);
	assign branchWait = isBranch && (srcHit(exCtrl.regWrite, exRd, rs1, rs2, 1'b1, 1'b1)
		|| srcHit(memStage.regWrite, memStage.rd, rs1, rs2, 1'b1, 1'b1));
	assign stall      = loadUse || branchWait;

	assign taken    = isJal || (isBranch && ((funct3 == Funct3Beq && rs1Val == rs2Val)
		|| (funct3 == Funct3Bne && rs1Val != rs2Val)));
	assign redirect = taken && !stall;
	assign target   = fdPc + (isJal ? immJ : immB);

	always_comb begin
		decExNext.ctrl   = stall ? '0 : ctrl;
		decExNext.pc     = fdPc;
		decExNext.rs1Val = rs1Val;
		decExNext.rs2Val = rs2Val;
		decExNext.imm    = imm;
		decExNext.rs1    = rs1;
		decExNext.rs2    = rs2;
		decExNext.rd     = rd;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			decEx.ctrl <= '0;
		end else begin
			decEx <= decExNext;
		end
	end

endmodule

//--- verilog/coreFetch.sv
////////////////////////////////////////////////////////////////////////////
// Program counter and fetch/decode register
// InstrData must be valid in the same cycle that PC is presented
// Decode never asserts redirect together with stall
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module coreFetch (
	input  logic           clk,
	input  logic           rstN,
	input  rvIsaPkg::wordT InstrData,
	input  logic           stall,
	input  logic           redirect,
	input  rvIsaPkg::addrT target,
	output rvIsaPkg::addrT pc,
	output rvIsaPkg::addrT fdPc,
	output rvIsaPkg::wordT fdInstr
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	addrT pcNext;

	// Taken branch or jal overrides the sequential step
	assign pcNext = redirect ? target : pc + PcStep;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= ResetPc;
		end else if (redirect || !stall) begin
			pc <= pcNext;
		end
	end

	// Squashed slot becomes an all-zero word, which decodes as a bubble
	always_ff @(posedge clk) begin
		if (!rstN || redirect) begin
			fdInstr <= '0;
		end else if (!stall) begin
			fdInstr <= InstrData;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fdPc <= pc;
		end
	end

endmodule

//--- verilog/rvPipePkg.sv
////////////////////////////////////////////////////////////////////////////
// Stage-to-stage payloads of the five-stage pipeline
// An all-zero ctrlT is a bubble, nothing is written anywhere
////////////////////////////////////////////////////////////////////////////

package rvPipePkg;

	localparam rvIsaPkg::addrT   ResetPc = 32'h0000_0000;
	localparam rvIsaPkg::addrT   PcStep  = 32'd4;
	localparam rvIsaPkg::regIdxT ZeroReg = 5'd0;

	// Decoded control carried into execute
	typedef struct packed {
		logic            regWrite;
		logic            memRead;
		logic            memWrite;
		logic            aluImm;
		logic            aluPc;
		rvIsaPkg::aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		ctrlT             ctrl;
		rvIsaPkg::addrT   pc;
		rvIsaPkg::wordT   rs1Val;
		rvIsaPkg::wordT   rs2Val;
		rvIsaPkg::wordT   imm;
		rvIsaPkg::regIdxT rs1;
		rvIsaPkg::regIdxT rs2;
		rvIsaPkg::regIdxT rd;
	} decExT;

	// Also drives the data memory ports directly
	typedef struct packed {
		rvIsaPkg::wordT   aluOut;
		rvIsaPkg::wordT   storeData;
		rvIsaPkg::regIdxT rd;
		logic             regWrite;
		logic             memRead;
		logic             memWrite;
	} exMemT;

	typedef struct packed {
		logic             regWrite;
		rvIsaPkg::regIdxT rd;
		rvIsaPkg::wordT   data;
	} wbT;

endpackage

//--- verilog/rvIsaPkg.sv
////////////////////////////////////////////////////////////////////////////
// RV32I encoding subset used by the core
// Only the opcodes and funct3 values of the kept instructions are listed
// Shifts, sltu, jalr, lui, auipc and sub-word accesses are not decoded
////////////////////////////////////////////////////////////////////////////

package rvIsaPkg;

	typedef logic [31:0] wordT;
	typedef logic [31:0] addrT;
	typedef logic [4:0]  regIdxT;

	// Major opcodes
	localparam logic [6:0] OpReg    = 7'b0110011;
	localparam logic [6:0] OpImm    = 7'b0010011;
	localparam logic [6:0] OpLoad   = 7'b0000011;
	localparam logic [6:0] OpStore  = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJal    = 7'b1101111;

	// Branch compare kinds
	localparam logic [2:0] Funct3Beq = 3'b000;
	localparam logic [2:0] Funct3Bne = 3'b001;

	// ALU kinds, shared by register and immediate forms
	localparam logic [2:0] Funct3Add = 3'b000;
	localparam logic [2:0] Funct3Slt = 3'b010;
	localparam logic [2:0] Funct3Xor = 3'b100;
	localparam logic [2:0] Funct3Or  = 3'b110;
	localparam logic [2:0] Funct3And = 3'b111;

	// Bit of funct7 that turns add into sub
	localparam int Funct7Sub = 5;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluSlt
	} aluOpT;

endpackage
